//--- include/sad_defs.svh
`ifndef SAD_DEFS_SVH
`define SAD_DEFS_SVH

// adc sample width in bits
`define SAD_BITS_PER_SAMPLE 8

// reference length, also the number of staggered lanes
`define SAD_REF_SAMPLES 32

// accumulator and threshold width
// 32 samples of at most 255 each stay well clear of the top bit
`define SAD_COUNTER_WIDTH 16

// enough bits to address every reference entry
`define SAD_INDEX_WIDTH 5

// trigger count width
`define SAD_NUM_TRIG_WIDTH 16

// edges from the capture of a window's last sample to trigger high
// front end (1), lane pipeline (4) and the trigger register (1) overlap as
// capture, decision, increment, accumulate, hit compare, trigger
`define SAD_TRIGGER_LATENCY 5

`endif

//--- verilog/sad_data_pkg.sv
`default_nettype none

`include "sad_defs.svh"

package sad_data_pkg;

    // one adc or reference sample
    typedef logic [`SAD_BITS_PER_SAMPLE-1:0] sample_t;

    // accumulator, per-sample increment or threshold
    typedef logic [`SAD_COUNTER_WIDTH-1:0] sad_count_t;

    // position inside the reference waveform
    typedef logic [`SAD_INDEX_WIDTH-1:0] ref_index_t;

endpackage

`default_nettype wire

//--- verilog/sad_ctrl_pkg.sv
`default_nettype none

`include "sad_defs.svh"

package sad_ctrl_pkg;

    // one bit per lane
    typedef logic [`SAD_REF_SAMPLES-1:0] lane_mask_t;

    typedef logic [`SAD_NUM_TRIG_WIDTH-1:0] trig_count_t;  // triggers since last clear

endpackage

`default_nettype wire

//--- verilog/sad_ref_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "sad_defs.svh"

module sad_ref_store import sad_data_pkg::*; (
    input  logic       adc_sampleclk,
    input  logic       reset,

    // host load port, four-phase req/ack
    input  logic       ref_req,
    output logic       ref_ack,
    input  ref_index_t ref_index,
    input  sample_t    ref_value,

    // lane 0 side
    input  ref_index_t read_index,
    output sample_t    read_sample
);

    sample_t ref_mem [`SAD_REF_SAMPLES];
    logic    load_strobe;

    // one write per request, on the edge that raises ack
    assign load_strobe = ref_req && !ref_ack;

    // ack simply follows req one edge later
    // so it rises after req rises and drops after req drops
    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            ref_ack <= 1'b0;
        end else begin
            ref_ack <= ref_req;
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (load_strobe) begin
            ref_mem[ref_index] <= ref_value;  // index and value held by host
        end
    end

    // combinational read, registered in lane 0
    assign read_sample = ref_mem[read_index];

endmodule

`default_nettype wire

//--- verilog/sad_front_end.sv
`timescale 1ns/1ps
`default_nettype none

`include "sad_defs.svh"

module sad_front_end import sad_data_pkg::*, sad_ctrl_pkg::*; (
    input  logic       adc_sampleclk,
    input  logic       reset,

    input  sample_t    adc_datain,
    input  logic       armed,
    input  logic       active,

    output sample_t    sample,
    output ref_index_t read_index,
    output lane_mask_t restart,
    output lane_mask_t ready
);

    localparam ref_index_t last_index = ref_index_t'(`SAD_REF_SAMPLES - 1);

    // lane i restarts three edges after its first sample is captured
    // so the ring starts three lanes behind lane 0
    localparam lane_mask_t ring_preset = {2'b00, 1'b1, {(`SAD_REF_SAMPLES-3){1'b0}}};

    logic running;
    logic pass_done;

    assign running   = armed && active;
    assign pass_done = (read_index == last_index);  // last entry goes out to lane 0 now

    // sample register with no back-pressure
    always_ff @(posedge adc_sampleclk) begin
        sample <= adc_datain;
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            read_index <= '0;
            restart    <= ring_preset;
            ready      <= '0;
        end else if (!running) begin
            // leaving the running state restarts numbering
            read_index <= '0;
            restart    <= ring_preset;
            ready      <= '0;
        end else begin
            read_index <= read_index + 1'b1;  // wraps from the last entry to 0

            // one-hot ring moves one lane further per edge
            restart <= {restart[`SAD_REF_SAMPLES-2:0], restart[`SAD_REF_SAMPLES-1]};

            // lane 0 becomes ready once the first pass is out and stays ready
            // later lanes follow one edge apart
            ready <= {ready[`SAD_REF_SAMPLES-2:0], ready[0] | pass_done};
        end
    end

endmodule

`default_nettype wire

//--- verilog/sad_lane.sv
`timescale 1ns/1ps
`default_nettype none

module sad_lane import sad_data_pkg::*; (
    input  logic       adc_sampleclk,

    input  sample_t    sample,
    input  sample_t    ref_in,
    output sample_t    ref_out,

    input  logic       restart,
    input  logic       ready,
    input  sad_count_t threshold,

    output logic       hit
);

    sample_t    ref_q;       // reference matching the sample in the front end
    sample_t    ref_d;
    sample_t    sample_d;
    logic       above;       // sample above reference
    sad_count_t incr;
    sad_count_t acc;

    // next lane sees the same reference one sample later
    assign ref_out = ref_q;

    // reference delay and compare decision
    always_ff @(posedge adc_sampleclk) begin
        ref_q    <= ref_in;
        ref_d    <= ref_q;
        sample_d <= sample;
        above    <= (sample > ref_q);
    end

    // absolute difference, widened to the accumulator
    always_ff @(posedge adc_sampleclk) begin
        if (above) begin
            incr <= sad_count_t'(sample_d) - sad_count_t'(ref_d);
        end else begin
            incr <= sad_count_t'(ref_d) - sad_count_t'(sample_d);
        end
    end

    // restart reloads with the first increment of the next window
    always_ff @(posedge adc_sampleclk) begin
        if (restart) begin
            acc <= incr;
        end else begin
            acc <= acc + incr;
        end
    end

    // acc holds the finished window on the restart edge
    always_ff @(posedge adc_sampleclk) begin
        hit <= restart && ready && (acc <= threshold);
    end

endmodule

`default_nettype wire

//--- verilog/sad_trigger.sv
`timescale 1ns/1ps
`default_nettype none

module sad_trigger import sad_ctrl_pkg::*; (
    input  logic        adc_sampleclk,
    input  logic        reset,

    input  lane_mask_t  hits,
    input  logic        armed,
    input  logic        active,
    input  logic        multiple_triggers,
    input  logic        status_clear,

    output logic        trigger,
    output logic        triggered,
    output trig_count_t num_triggers
);

    logic armed_q;
    logic arm_rise;
    logic running;
    logic suppress;

    assign running  = armed && active;
    assign arm_rise = armed && !armed_q;

    // single-trigger mode holds off after the first pulse
    assign suppress = triggered && !multiple_triggers;

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            armed_q <= 1'b0;
            trigger <= 1'b0;
        end else begin
            armed_q <= armed;
            trigger <= running && (|hits) && !suppress;  // at most one lane closes per edge
        end
    end

    // status, clear wins over a coincident pulse
    always_ff @(posedge adc_sampleclk) begin
        if (reset || status_clear || arm_rise) begin
            triggered    <= 1'b0;
            num_triggers <= '0;
        end else if (trigger) begin
            triggered    <= 1'b1;
            num_triggers <= num_triggers + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- verilog/sad_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "sad_defs.svh"

module sad_top import sad_data_pkg::*, sad_ctrl_pkg::*; (
    input  logic        adc_sampleclk,
    input  logic        reset,

    input  sample_t     adc_datain,
    input  logic        armed,
    input  logic        active,

    input  logic        ref_req,
    output logic        ref_ack,
    input  ref_index_t  ref_index,
    input  sample_t     ref_value,

    input  sad_count_t  threshold,
    input  logic        multiple_triggers,
    input  logic        status_clear,

    output logic        trigger,
    output logic        triggered,
    output trig_count_t num_triggers
);

    sample_t    sample;
    ref_index_t read_index;
    lane_mask_t restart;
    lane_mask_t ready;
    lane_mask_t hits;

    // reference chain, entry 0 from the store, entry i+1 out of lane i
    sample_t [`SAD_REF_SAMPLES:0] ref_chain;

    sad_ref_store u_ref_store (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .ref_req       (ref_req),
        .ref_ack       (ref_ack),
        .ref_index     (ref_index),
        .ref_value     (ref_value),
        .read_index    (read_index),
        .read_sample   (ref_chain[0])
    );

    sad_front_end u_front_end (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .adc_datain    (adc_datain),
        .armed         (armed),
        .active        (active),
        .sample        (sample),
        .read_index    (read_index),
        .restart       (restart),
        .ready         (ready)
    );

    // lane i starts a window on samples i, i+32, ...
    for (genvar i = 0; i < `SAD_REF_SAMPLES; i++) begin : g_lane
        sad_lane u_lane (
            .adc_sampleclk (adc_sampleclk),
            .sample        (sample),
            .ref_in        (ref_chain[i]),
            .ref_out       (ref_chain[i+1]),
            .restart       (restart[i]),
            .ready         (ready[i]),
            .threshold     (threshold),
            .hit           (hits[i])
        );
    end

    sad_trigger u_trigger (
        .adc_sampleclk     (adc_sampleclk),
        .reset             (reset),
        .hits              (hits),
        .armed             (armed),
        .active            (active),
        .multiple_triggers (multiple_triggers),
        .status_clear      (status_clear),
        .trigger           (trigger),
        .triggered         (triggered),
        .num_triggers      (num_triggers)
    );

endmodule

`default_nettype wire

//--- dv/sad_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "sad_defs.svh"

module sad_tb import sad_data_pkg::*, sad_ctrl_pkg::*; ();

    localparam int LEAD     = 20;   // noise ahead of the pattern
    localparam int TRAIL    = 10;   // noise after the pattern
    localparam int TAIL     = 8;    // disarmed edges after the last sample
    localparam int NUM_ROWS = 7;
    localparam int ACK_WAIT = 8;
    localparam sample_t OFFSET = 8'd3;

    typedef enum logic [1:0] {STIM_EXACT, STIM_OFFSET, STIM_REPEAT, STIM_NOISE} stim_kind_t;

    typedef struct packed {
        stim_kind_t  kind;
        sad_count_t  threshold;
        logic        multi;
        logic        act;         // active during the row
        logic        clear;       // status_clear pulse after the row
        trig_count_t exp_count;
    } row_t;

    logic        adc_sampleclk;
    logic        reset;
    sample_t     adc_datain;
    logic        armed;
    logic        active;
    logic        ref_req;
    logic        ref_ack;
    ref_index_t  ref_index;
    sample_t     ref_value;
    sad_count_t  threshold;
    logic        multiple_triggers;
    logic        status_clear;
    logic        trigger;
    logic        triggered;
    trig_count_t num_triggers;

    row_t        rows [NUM_ROWS];
    sample_t     ref_mem [`SAD_REF_SAMPLES];
    sample_t     stim [$];
    logic        exp_trig [$];   // expected trigger after each edge of a row
    logic [31:0] rng;
    int          model_count;
    int          mismatches;
    int          failures;
    int          cycles;
    int          cycle_limit;

    sad_top DUT (
        .adc_sampleclk     (adc_sampleclk),
        .reset             (reset),
        .adc_datain        (adc_datain),
        .armed             (armed),
        .active            (active),
        .ref_req           (ref_req),
        .ref_ack           (ref_ack),
        .ref_index         (ref_index),
        .ref_value         (ref_value),
        .threshold         (threshold),
        .multiple_triggers (multiple_triggers),
        .status_clear      (status_clear),
        .trigger           (trigger),
        .triggered         (triggered),
        .num_triggers      (num_triggers)
    );

    always #10 adc_sampleclk = ~adc_sampleclk;

    always @(posedge adc_sampleclk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles, %0d mismatches and %0d other errors so far",
                     cycles, mismatches, failures);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic sample_t next_sample();
        rng = xorshift(rng);
        return rng[7:0];
    endfunction

    function automatic int stim_length(input stim_kind_t kind);
        return LEAD + ((kind == STIM_REPEAT) ? 2 : 1) * `SAD_REF_SAMPLES + TRAIL;
    endfunction

    function automatic void build_stimulus(input stim_kind_t kind);
        int c;
        int i;
        stim.delete();
        for (i = 0; i < LEAD; i++) begin
            stim.push_back(next_sample());
        end
        for (c = 0; c < ((kind == STIM_REPEAT) ? 2 : 1); c++) begin
            for (i = 0; i < `SAD_REF_SAMPLES; i++) begin
                case (kind)
                    STIM_OFFSET: stim.push_back(ref_mem[i] + OFFSET);
                    STIM_NOISE:  stim.push_back(next_sample());
                    default:     stim.push_back(ref_mem[i]);
                endcase
            end
        end
        for (i = 0; i < TRAIL; i++) begin
            stim.push_back(next_sample());
        end
    endfunction

    // sad of the window ending at sample k, against entries 0 to 31
    function automatic int window_sad(input int k);
        int sum;
        int d;
        int j;
        sum = 0;
        for (j = 0; j < `SAD_REF_SAMPLES; j++) begin
            d = int'(stim[k - `SAD_REF_SAMPLES + 1 + j]) - int'(ref_mem[j]);
            sum += (d < 0) ? -d : d;
        end
        return sum;
    endfunction

    function automatic void predict(input row_t row);
        int e;
        int k;
        exp_trig.delete();
        model_count = 0;
        for (e = 0; e < stim.size() + TAIL; e++) begin
            k = e - `SAD_TRIGGER_LATENCY;   // sample whose window closes here
            if (row.act && e < stim.size() && k >= `SAD_REF_SAMPLES - 1 &&
                window_sad(k) <= int'(row.threshold) &&
                (row.multi || model_count == 0)) begin
                exp_trig.push_back(1'b1);
                model_count++;
            end else begin
                exp_trig.push_back(1'b0);
            end
        end
    endfunction

    task automatic check_bit(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            mismatches++;
            $display("Mismatch at %0t: %s expected %0b got %0b", $time, name, expected, got);
        end
    endtask

    task automatic check_count(input string name, input trig_count_t got,
                               input trig_count_t expected);
        if (got !== expected) begin
            mismatches++;
            $display("Mismatch at %0t: %s expected %0d got %0d", $time, name, expected, got);
        end
    endtask

    task automatic report_failure(input string msg);
        failures++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    // four-phase load of one entry, called on a falling edge
    task automatic load_entry(input ref_index_t idx, input sample_t val);
        int waited;
        if (ref_ack !== 1'b0) begin
            report_failure("ref_ack already high before ref_req");
        end
        ref_index = idx;
        ref_value = val;
        ref_req   = 1'b1;
        waited    = 0;
        while (ref_ack !== 1'b1 && waited < ACK_WAIT) begin
            @(negedge adc_sampleclk);
            waited++;
        end
        if (ref_ack !== 1'b1) begin
            report_failure($sformatf("ref_ack never rose for entry %0d", idx));
        end
        ref_req = 1'b0;
        waited  = 0;
        while (ref_ack !== 1'b0 && waited < ACK_WAIT) begin
            @(negedge adc_sampleclk);
            waited++;
        end
        if (ref_ack !== 1'b0) begin
            report_failure($sformatf("ref_ack stayed high after entry %0d", idx));
        end
    endtask

    initial begin
        int r;
        int e;
        int n;
        int i;
        adc_sampleclk     = 1'b0;
        reset             = 1'b1;
        adc_datain        = '0;
        armed             = 1'b0;
        active            = 1'b0;
        ref_req           = 1'b0;
        ref_index         = '0;
        ref_value         = '0;
        threshold         = '0;
        multiple_triggers = 1'b0;
        status_clear      = 1'b0;
        rng               = 32'hcab8;
        mismatches        = 0;
        failures          = 0;
        cycles            = 0;

        // kind, threshold, multi, active, clear after, expected triggers
        rows[0] = '{STIM_EXACT,  16'd0,   1'b0, 1'b1, 1'b0, 16'd1};
        rows[1] = '{STIM_OFFSET, 16'd96,  1'b0, 1'b1, 1'b1, 16'd1};  // sad is 32 * 3
        rows[2] = '{STIM_OFFSET, 16'd95,  1'b0, 1'b1, 1'b0, 16'd0};
        rows[3] = '{STIM_REPEAT, 16'd10,  1'b0, 1'b1, 1'b0, 16'd1};
        rows[4] = '{STIM_REPEAT, 16'd10,  1'b1, 1'b1, 1'b0, 16'd2};
        rows[5] = '{STIM_EXACT,  16'd10,  1'b0, 1'b0, 1'b0, 16'd0};
        rows[6] = '{STIM_NOISE,  16'd200, 1'b1, 1'b1, 1'b0, 16'd0};

        cycle_limit = 20 + `SAD_REF_SAMPLES * 2 * ACK_WAIT;
        for (r = 0; r < NUM_ROWS; r++) begin
            cycle_limit += stim_length(rows[r].kind) + TAIL + 4;
        end

        repeat (10) @(negedge adc_sampleclk);
        reset = 1'b0;
        check_bit("trigger", trigger, 1'b0);
        check_bit("ref_ack", ref_ack, 1'b0);
        check_bit("triggered", triggered, 1'b0);
        check_count("num_triggers", num_triggers, '0);

        // reference values leave room for the offset pattern
        for (i = 0; i < `SAD_REF_SAMPLES; i++) begin
            ref_mem[i] = 8'd16 + (next_sample() % 8'd200);
            load_entry(ref_index_t'(i), ref_mem[i]);
        end

        for (r = 0; r < NUM_ROWS; r++) begin
            build_stimulus(rows[r].kind);
            predict(rows[r]);
            n = stim.size();
            if (trig_count_t'(model_count) != rows[r].exp_count) begin
                report_failure($sformatf("row %0d model gives %0d triggers, table %0d",
                                         r, model_count, rows[r].exp_count));
            end
            threshold         = rows[r].threshold;
            multiple_triggers = rows[r].multi;
            armed             = 1'b1;
            active            = rows[r].act;
            adc_datain        = stim[0];
            for (e = 0; e < n + TAIL; e++) begin
                @(negedge adc_sampleclk);
                if (e == 0) begin   // rising arm clears status
                    check_bit("triggered", triggered, 1'b0);
                    check_count("num_triggers", num_triggers, '0);
                end
                check_bit("trigger", trigger, exp_trig[e]);
                if (e + 1 < n) begin
                    adc_datain = stim[e + 1];
                end else begin
                    armed  = 1'b0;
                    active = 1'b0;
                end
            end
            check_count("num_triggers", num_triggers, rows[r].exp_count);
            check_bit("triggered", triggered, rows[r].exp_count != '0);
            if (rows[r].clear) begin
                status_clear = 1'b1;
                @(negedge adc_sampleclk);
                status_clear = 1'b0;
                check_bit("triggered", triggered, 1'b0);
                check_count("num_triggers", num_triggers, '0);
            end
        end

        $display("checks finished with %0d mismatches and %0d other errors",
                 mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+include
verilog/sad_data_pkg.sv
verilog/sad_ctrl_pkg.sv
verilog/sad_ref_store.sv
verilog/sad_front_end.sv
verilog/sad_lane.sv
verilog/sad_trigger.sv
verilog/sad_top.sv
dv/sad_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
TOP       ?= sad_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf $(OBJ_DIR)
